// File: gpio_reg_pkg.sv
package gpio_reg_pkg;

    localparam int apb_data_w = 32;
    localparam int reg_idx_w  = 5;  // PADDR[6:2]

    typedef enum logic [reg_idx_w-1:0] {
        reg_paddir     = 5'd0,
        reg_gpioen     = 5'd1,
        reg_padin      = 5'd2,
        reg_padout     = 5'd3,
        reg_padoutset  = 5'd4,
        reg_padoutclr  = 5'd5,
        reg_inten      = 5'd6,
        reg_inttype_lo = 5'd7,  // Pads 0 to 15
        reg_inttype_hi = 5'd8,  // Pads 16 to 31
        reg_intstatus  = 5'd9
    } reg_idx_e;

    typedef enum logic [1:0] {
        int_fall = 2'b00,
        int_rise = 2'b01,
        int_both = 2'b10,
        int_none = 2'b11   // Never triggers
    } int_type_e;

    // Same data word, per-pad bits or per-pad type fields
    typedef union packed {
        logic [apb_data_w-1:0]                bits;
        int_type_e [apb_data_w/2-1:0]         types;
    } apb_word_u;

    typedef struct packed {
        logic      wr;
        logic      rd;
        reg_idx_e  idx;
        apb_word_u wdata;
    } reg_access_t;

endpackage

// File: gpio_pad_pkg.sv
package gpio_pad_pkg;

    // Upper bound of pad_num
    localparam int max_pads = 32;

    // Edge flags per pad, bits at and above pad_num stay zero
    typedef struct packed {
        logic [max_pads-1:0] rise;
        logic [max_pads-1:0] fall;
    } pad_edges_t;

endpackage

// File: gpio_apb_decode.sv
module gpio_apb_decode #(
    parameter int apb_addr_w = 12
) (
    input  logic [apb_addr_w-1:0]              PADDR,
    input  logic [gpio_reg_pkg::apb_data_w-1:0] PWDATA,
    input  logic                               PWRITE,
    input  logic                               PSEL,
    input  logic                               PENABLE,
    output gpio_reg_pkg::reg_access_t          access,
    output logic                               status_rd
);

    import gpio_reg_pkg::*;

    logic     acc_phase;
    reg_idx_e idx;

    // Enable phase, APB never waits here
    assign acc_phase = PSEL & PENABLE;

    // Word index, unmapped values pass through and read as zero
    assign idx = reg_idx_e'(PADDR[reg_idx_w+1:2]);

    assign access.wr         = acc_phase & PWRITE;
    assign access.rd         = acc_phase & ~PWRITE;
    assign access.idx        = idx;
    assign access.wdata.bits = PWDATA;

    // Clear-on-read strobe for the status register
    assign status_rd = acc_phase && !PWRITE && (idx == reg_intstatus);

endmodule

// File: gpio_in_sync.sv
module gpio_in_sync #(
    parameter int pad_num = 32
) (
    input  logic                     HCLK,
    input  logic                     HRESETn,
    input  logic [pad_num-1:0]       gpio_in,
    input  logic [pad_num-1:0]       gpio_en,
    output logic [pad_num-1:0]       gpio_in_sync,
    output logic [pad_num-1:0]       pad_in,
    output gpio_pad_pkg::pad_edges_t edges
);

    import gpio_pad_pkg::*;

    localparam int grp_num = (pad_num + 3) / 4;

    logic [4*grp_num-1:0] en_ext;
    logic [grp_num-1:0]   grp_en;
    logic [pad_num-1:0]   s0;
    logic [pad_num-1:0]   s1;
    logic [pad_num-1:0]   s2;

    // One enable per group of four pads
    always_comb
    begin
        en_ext = '0;
        en_ext[pad_num-1:0] = gpio_en;
        for (int g = 0; g < grp_num; g++)
            grp_en[g] = |en_ext[4*g +: 4];
    end

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            s0 <= '0;
            s1 <= '0;
            s2 <= '0;
        end
        else
        begin
            for (int i = 0; i < pad_num; i++)
            begin
                if (grp_en[i/4])  // Idle groups hold all stages
                begin
                    s0[i] <= gpio_in[i];
                    s1[i] <= s0[i];
                    s2[i] <= s1[i];
                end
            end
        end
    end

    assign gpio_in_sync = s1;
    assign pad_in       = s2;

    always_comb
    begin
        edges = '0;
        edges.rise[pad_num-1:0] = s1 & ~s2;
        edges.fall[pad_num-1:0] = ~s1 & s2;
    end

endmodule

// File: gpio_regs.sv
module gpio_regs #(
    parameter int pad_num = 32
) (
    input  logic                                  HCLK,
    input  logic                                  HRESETn,
    input  gpio_reg_pkg::reg_access_t             access,
    input  logic [pad_num-1:0]                    pad_in,
    input  logic [pad_num-1:0]                    status,
    output logic [gpio_reg_pkg::apb_data_w-1:0]   PRDATA,
    output logic [pad_num-1:0]                    gpio_dir,
    output logic [pad_num-1:0]                    gpio_out,
    output logic [pad_num-1:0]                    gpio_en,
    output logic [pad_num-1:0]                    inten,
    output gpio_reg_pkg::int_type_e [pad_num-1:0] inttype
);

    import gpio_reg_pkg::*;

    logic [pad_num-1:0] wd;
    logic [pad_num-1:0] rd_pads;
    logic               rd_is_pads;
    apb_word_u          rd_word;

    assign wd = access.wdata.bits[pad_num-1:0];

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            gpio_dir <= '0;
            gpio_out <= '0;
            gpio_en  <= '0;
            inten    <= '0;
            inttype  <= '0;
        end
        else if (access.wr)
        begin
            case (access.idx)
                reg_paddir:    gpio_dir <= wd;
                reg_gpioen:    gpio_en  <= wd;
                reg_padout:    gpio_out <= wd;
                reg_padoutset: gpio_out <= gpio_out | wd;
                reg_padoutclr: gpio_out <= gpio_out & ~wd;
                reg_inten:     inten    <= wd;
                reg_inttype_lo:
                begin
                    for (int i = 0; i < pad_num && i < 16; i++)
                        inttype[i] <= access.wdata.types[i];
                end
                reg_inttype_hi:
                begin
                    for (int i = 16; i < pad_num; i++)
                        inttype[i] <= access.wdata.types[i-16];
                end
                default: ;  // Read-only or unmapped
            endcase
        end
    end

    // Read word, zero outside a read and for unmapped indices
    always_comb
    begin
        rd_pads      = '0;
        rd_is_pads   = 1'b1;
        rd_word.bits = '0;
        if (access.rd)
        begin
            case (access.idx)
                reg_paddir:    rd_pads = gpio_dir;
                reg_gpioen:    rd_pads = gpio_en;
                reg_padin:     rd_pads = pad_in;
                reg_padout:    rd_pads = gpio_out;
                reg_inten:     rd_pads = inten;
                reg_intstatus: rd_pads = status;
                reg_inttype_lo:
                begin
                    rd_is_pads = 1'b0;
                    for (int i = 0; i < pad_num && i < 16; i++)
                        rd_word.types[i] = inttype[i];
                end
                reg_inttype_hi:
                begin
                    rd_is_pads = 1'b0;
                    for (int i = 16; i < pad_num; i++)
                        rd_word.types[i-16] = inttype[i];
                end
                default: rd_pads = '0;
            endcase
        end
        if (rd_is_pads)
            rd_word.bits[pad_num-1:0] = rd_pads;  // Upper bits stay zero
        PRDATA = rd_word.bits;
    end

endmodule

// File: gpio_irq.sv
module gpio_irq #(
    parameter int pad_num = 32
) (
    input  logic                                  HCLK,
    input  logic                                  HRESETn,
    input  gpio_pad_pkg::pad_edges_t              edges,
    input  logic [pad_num-1:0]                    gpio_en,
    input  logic [pad_num-1:0]                    inten,
    input  gpio_reg_pkg::int_type_e [pad_num-1:0] inttype,
    input  logic                                  status_rd,
    output logic [pad_num-1:0]                    status,
    output logic                                  interrupt
);

    import gpio_reg_pkg::*;
    import gpio_pad_pkg::*;

    logic [pad_num-1:0] match;
    logic [pad_num-1:0] hits;

    // Edge against the pad's configured type
    always_comb
    begin
        for (int i = 0; i < pad_num; i++)
        begin
            case (inttype[i])
                int_fall: match[i] = edges.fall[i];
                int_rise: match[i] = edges.rise[i];
                int_both: match[i] = edges.rise[i] | edges.fall[i];
                int_none: match[i] = 1'b0;
            endcase
        end
    end

    assign hits      = match & inten & gpio_en;
    assign interrupt = |hits;

    // New hits win over a clear in the same cycle
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
            status <= '0;
        else if (interrupt)
            status <= status | hits;
        else if (status_rd)
            status <= '0;
    end

endmodule

// File: apb_gpio.sv
module apb_gpio #(
    parameter int apb_addr_w = 12,
    parameter int pad_num    = 32
) (
    input  logic                               HCLK,
    input  logic                               HRESETn,
    input  logic [apb_addr_w-1:0]              PADDR,
    input  logic [gpio_reg_pkg::apb_data_w-1:0] PWDATA,
    input  logic                               PWRITE,
    input  logic                               PSEL,
    input  logic                               PENABLE,
    output logic [gpio_reg_pkg::apb_data_w-1:0] PRDATA,
    output logic                               PREADY,
    output logic                               PSLVERR,
    input  logic [pad_num-1:0]                 gpio_in,
    output logic [pad_num-1:0]                 gpio_in_sync,
    output logic [pad_num-1:0]                 gpio_out,
    output logic [pad_num-1:0]                 gpio_dir,
    output logic                               interrupt
);

    import gpio_reg_pkg::*;
    import gpio_pad_pkg::*;

    reg_access_t               access;
    logic                      status_rd;
    logic [pad_num-1:0]        pad_in;
    pad_edges_t                edges;
    logic [pad_num-1:0]        gpio_en;
    logic [pad_num-1:0]        inten;
    int_type_e [pad_num-1:0]   inttype;
    logic [pad_num-1:0]        status;

    // No wait states, no errors
    assign PREADY  = 1'b1;
    assign PSLVERR = 1'b0;

    gpio_apb_decode #(
        .apb_addr_w (apb_addr_w)
    ) u_decode (
        .PADDR     (PADDR),
        .PWDATA    (PWDATA),
        .PWRITE    (PWRITE),
        .PSEL      (PSEL),
        .PENABLE   (PENABLE),
        .access    (access),
        .status_rd (status_rd)
    );

    gpio_in_sync #(
        .pad_num (pad_num)
    ) u_in_sync (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .gpio_in      (gpio_in),
        .gpio_en      (gpio_en),
        .gpio_in_sync (gpio_in_sync),
        .pad_in       (pad_in),
        .edges        (edges)
    );

    gpio_regs #(
        .pad_num (pad_num)
    ) u_regs (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .access   (access),
        .pad_in   (pad_in),
        .status   (status),
        .PRDATA   (PRDATA),
        .gpio_dir (gpio_dir),
        .gpio_out (gpio_out),
        .gpio_en  (gpio_en),
        .inten    (inten),
        .inttype  (inttype)
    );

    gpio_irq #(
        .pad_num (pad_num)
    ) u_irq (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .edges     (edges),
        .gpio_en   (gpio_en),
        .inten     (inten),
        .inttype   (inttype),
        .status_rd (status_rd),
        .status    (status),
        .interrupt (interrupt)
    );

endmodule

// File: tb_apb_gpio.sv
module tb_apb_gpio;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int pad_num  = 32;
    localparam int clk_half = 50;

    localparam logic [11:0] a_paddir     = 12'h000;
    localparam logic [11:0] a_gpioen     = 12'h004;
    localparam logic [11:0] a_padin      = 12'h008;
    localparam logic [11:0] a_padout     = 12'h00C;
    localparam logic [11:0] a_padoutset  = 12'h010;
    localparam logic [11:0] a_padoutclr  = 12'h014;
    localparam logic [11:0] a_inten      = 12'h018;
    localparam logic [11:0] a_inttype_lo = 12'h01C;
    localparam logic [11:0] a_inttype_hi = 12'h020;
    localparam logic [11:0] a_intstatus  = 12'h024;
    localparam logic [11:0] a_unmapped   = 12'h03C;

    typedef enum logic [2:0] {
        op_wr, op_rd, op_pads, op_wait, op_irq, op_out, op_dir, op_sync
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [11:0] addr;  // Cycle count for op_wait and op_irq
        logic [31:0] data;
        logic [31:0] exp;
    } step_t;

    logic               HCLK;
    logic               HRESETn;
    logic [11:0]        PADDR;
    logic [31:0]        PWDATA;
    logic               PWRITE;
    logic               PSEL;
    logic               PENABLE;
    logic [31:0]        PRDATA;
    logic               PREADY;
    logic               PSLVERR;
    logic [pad_num-1:0] gpio_in;
    logic [pad_num-1:0] gpio_in_sync;
    logic [pad_num-1:0] gpio_out;
    logic [pad_num-1:0] gpio_dir;
    logic               interrupt;

    step_t tbl[$];
    int    seed = 14220;
    bit    tbl_ready = 1'b0;
    int    cycles;
    int    limit;

    apb_gpio #(
        .apb_addr_w (12),
        .pad_num    (pad_num)
    ) dut0 (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .PADDR        (PADDR),
        .PWDATA       (PWDATA),
        .PWRITE       (PWRITE),
        .PSEL         (PSEL),
        .PENABLE      (PENABLE),
        .PRDATA       (PRDATA),
        .PREADY       (PREADY),
        .PSLVERR      (PSLVERR),
        .gpio_in      (gpio_in),
        .gpio_in_sync (gpio_in_sync),
        .gpio_out     (gpio_out),
        .gpio_dir     (gpio_dir),
        .interrupt    (interrupt)
    );

    initial
    begin
        HCLK = 1'b0;
        forever #(clk_half) HCLK = ~HCLK;
    end

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "check on %s failed", name);
        end
    endtask

    task automatic add_step(input op_e op, input logic [11:0] addr,
                            input logic [31:0] data, input logic [31:0] exp);
        tbl.push_back(step_t'{op, addr, data, exp});
    endtask

    // Hits of the enabled pads for one change of the pad word
    function automatic logic [31:0] expected_hits(input logic [31:0] prev,
            input logic [31:0] next, input logic [31:0] types, input logic [31:0] mask);
        logic [31:0] hits;
        logic        rise;
        logic        fall;
        hits = '0;
        for (int i = 0; i < 16; i++)
        begin
            rise = next[i] & ~prev[i];
            fall = ~next[i] & prev[i];
            case (types[2*i +: 2])
                2'b00:   hits[i] = fall;
                2'b01:   hits[i] = rise;
                2'b10:   hits[i] = rise | fall;
                default: hits[i] = 1'b0;
            endcase
        end
        return hits & mask;
    endfunction

    task automatic build_table();
        logic [31:0] dir;
        logic [31:0] en;
        logic [31:0] ie;
        logic [31:0] tlo;
        logic [31:0] thi;
        logic [31:0] out;
        logic [31:0] r;
        logic [31:0] prev;
        logic [31:0] next;
        logic [31:0] hits;
        add_step(op_rd, a_paddir, '0, '0);
        add_step(op_rd, a_padout, '0, '0);
        add_step(op_rd, a_gpioen, '0, '0);
        add_step(op_rd, a_inten, '0, '0);
        add_step(op_rd, a_inttype_lo, '0, '0);
        add_step(op_rd, a_inttype_hi, '0, '0);
        add_step(op_rd, a_intstatus, '0, '0);
        add_step(op_irq, 12'd3, '0, '0);
        dir = $random(seed);
        en  = $random(seed);
        ie  = $random(seed);
        tlo = $random(seed);
        thi = $random(seed);
        add_step(op_wr, a_paddir, dir, '0);
        add_step(op_wr, a_gpioen, en, '0);
        add_step(op_wr, a_inten, ie, '0);
        add_step(op_wr, a_inttype_lo, tlo, '0);
        add_step(op_wr, a_inttype_hi, thi, '0);
        add_step(op_rd, a_paddir, '0, dir);
        add_step(op_rd, a_gpioen, '0, en);
        add_step(op_rd, a_inten, '0, ie);
        add_step(op_rd, a_inttype_lo, '0, tlo);
        add_step(op_rd, a_inttype_hi, '0, thi);
        add_step(op_dir, '0, '0, dir);
        out = $random(seed);
        add_step(op_wr, a_padout, out, '0);
        add_step(op_out, '0, '0, out);
        add_step(op_rd, a_padout, '0, out);
        r   = $random(seed);
        out = out | r;
        add_step(op_wr, a_padoutset, r, '0);
        add_step(op_out, '0, '0, out);
        add_step(op_rd, a_padout, '0, out);
        r   = $random(seed);
        out = out & ~r;
        add_step(op_wr, a_padoutclr, r, '0);
        add_step(op_out, '0, '0, out);
        add_step(op_rd, a_padout, '0, out);
        // Only group 0 samples, no interrupts yet
        en = 32'h0000_000F;
        add_step(op_wr, a_inten, '0, '0);
        add_step(op_wr, a_gpioen, en, '0);
        r = $random(seed);
        add_step(op_pads, '0, r, '0);
        add_step(op_wait, 12'd1, '0, '0);
        add_step(op_sync, '0, '0, '0);  // Still in the first stage
        add_step(op_wait, 12'd1, '0, '0);
        add_step(op_sync, '0, '0, r & en);
        add_step(op_wait, 12'd1, '0, '0);
        add_step(op_rd, a_padin, '0, r & en);
        // Pad 0 fall, pad 1 rise, pad 2 both, pad 3 rise
        tlo = 32'h0000_0064;
        add_step(op_wr, a_inttype_lo, tlo, '0);
        add_step(op_wr, a_inttype_hi, '0, '0);
        add_step(op_pads, '0, '0, '0);
        add_step(op_wait, 12'd3, '0, '0);
        add_step(op_rd, a_padin, '0, '0);
        add_step(op_wr, a_inten, en, '0);
        add_step(op_rd, a_intstatus, '0, '0);
        prev = '0;
        for (int s = 0; s < 14; s++)
        begin
            if (s < 8)
                next = (s % 2 == 0) ? (32'h1 << (s / 2)) : 32'h0;
            else
                next = $random(seed);
            hits = expected_hits(prev, next, tlo, en);
            add_step(op_pads, '0, next, '0);
            add_step(op_irq, 12'd3, '0, {31'b0, |hits});
            add_step(op_rd, a_intstatus, '0, hits);  // Also clears
            prev = next;
        end
        add_step(op_rd, a_intstatus, '0, '0);
        add_step(op_rd, a_unmapped, '0, '0);
        add_step(op_wr, a_unmapped, $random(seed), '0);
        add_step(op_rd, a_paddir, '0, dir);
        add_step(op_rd, a_padout, '0, out);
        add_step(op_rd, a_gpioen, '0, en);
        add_step(op_rd, a_inten, '0, en);
        add_step(op_rd, a_inttype_lo, '0, tlo);
        add_step(op_rd, a_inttype_hi, '0, '0);
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        PADDR   = addr;
        PWDATA  = data;
        PWRITE  = 1'b1;
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        @(negedge HCLK);
        PENABLE = 1'b1;
        @(negedge HCLK);
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic apb_read_check(input logic [11:0] addr, input logic [31:0] exp);
        PADDR   = addr;
        PWRITE  = 1'b0;
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        @(negedge HCLK);
        PENABLE = 1'b1;
        #(clk_half / 2);  // Mid enable phase
        compare_word("PRDATA", PRDATA, exp);
        compare_word("PREADY", {31'b0, PREADY}, 32'h1);
        compare_word("PSLVERR", {31'b0, PSLVERR}, 32'h0);
        @(negedge HCLK);
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic run_step(input step_t s);
        logic seen;
        seen = 1'b0;
        case (s.op)
            op_wr:   apb_write(s.addr, s.data);
            op_rd:   apb_read_check(s.addr, s.exp);
            op_pads: gpio_in = s.data[pad_num-1:0];
            op_wait: repeat (s.addr) @(negedge HCLK);
            op_irq:
            begin
                repeat (s.addr)
                begin
                    @(negedge HCLK);
                    seen |= interrupt;
                end
                compare_word("interrupt", {31'b0, seen}, s.exp);
            end
            op_out:  compare_word("gpio_out", gpio_out, s.exp);
            op_dir:  compare_word("gpio_dir", gpio_dir, s.exp);
            op_sync: compare_word("gpio_in_sync", gpio_in_sync, s.exp);
        endcase
    endtask

    initial
    begin
        HRESETn = 1'b0;
        PADDR   = '0;
        PWDATA  = '0;
        PWRITE  = 1'b0;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        gpio_in = '0;
        build_table();
        tbl_ready = 1'b1;
        repeat (4) @(posedge HCLK);
        @(negedge HCLK);
        HRESETn = 1'b1;
        foreach (tbl[i])
            run_step(tbl[i]);
        $display("TESTS PASSED");
        $finish;
    end

    initial
    begin
        wait (tbl_ready);
        limit  = tbl.size() * 8 + 20;
        cycles = 0;
        while (cycles < limit)
        begin
            @(posedge HCLK);
            cycles++;
        end
        $display("Run stopped after %0d cycles without finishing the test table", cycles);
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    end

endmodule

// File: vlog.f
gpio_reg_pkg.sv
gpio_pad_pkg.sv
gpio_apb_decode.sv
gpio_in_sync.sv
gpio_regs.sv
gpio_irq.sv
apb_gpio.sv
tb_apb_gpio.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_apb_gpio
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
